/* src/board_pkg.sv */
`default_nettype none

package board_pkg;

    localparam int grid_dim  = 4;  // tiles per side
    localparam int num_cells = grid_dim * grid_dim;
    localparam int tile_w    = 4;

    // one tile is an exponent, zero means the cell is empty
    typedef logic [tile_w-1:0] tile_t;

    // merges stop growing here
    localparam tile_t tile_max = tile_t'(15);

    // cell index is row * grid_dim + col, cell 0 in the low bits
    typedef tile_t [num_cells-1:0] grid_t;

    // index 0 is the head of the line, tiles slide toward it
    typedef tile_t [grid_dim-1:0] line_t;

    // bit d of the move strobe requests direction d
    typedef enum logic [1:0] {
        dir_left  = 2'd0,
        dir_right = 2'd1,
        dir_up    = 2'd2,
        dir_down  = 2'd3
    } dir_e;

    typedef struct packed {
        logic                         en;
        logic [$clog2(num_cells)-1:0] loc;
        tile_t                        value;
    } preset_t;

endpackage

`default_nettype wire

/* src/line_slider.sv */
`default_nettype none
`timescale 1ns/1ns

// slides one line of tiles toward index 0 and merges equal pairs once
module line_slider (
    input  wire board_pkg::line_t line_in,
    output board_pkg::line_t      line_out,
    output logic [3:0]            merged
);

    localparam int dim = board_pkg::grid_dim;

    // one spare slot past the end so the last tile has an empty partner
    board_pkg::tile_t [dim:0] comp;

    // pass 1, drop the gaps and keep order
    always_comb begin
        int n;
        comp = '0;
        n    = 0;
        for (int i = 0; i < dim; i++) begin
            if (line_in[i] != '0) begin
                comp[n] = line_in[i];
                n++;
            end
        end
    end

    // pass 2, merge from the head
    always_comb begin
        int   n;
        logic skip;  // tile already consumed by the merge before it
        line_out = '0;
        merged   = '0;
        n        = 0;
        skip     = 1'b0;
        for (int i = 0; i < dim; i++) begin
            if (skip) begin
                skip = 1'b0;
            end else if (comp[i] != '0) begin
                if (comp[i] == comp[i+1]) begin
                    if (comp[i] == board_pkg::tile_max)
                        line_out[n] = board_pkg::tile_max;  // saturate
                    else
                        line_out[n] = comp[i] + board_pkg::tile_t'(1);
                    merged[n] = 1'b1;
                    skip      = 1'b1;
                end else begin
                    line_out[n] = comp[i];
                end
                n++;
            end
        end
    end

endmodule

`default_nettype wire

/* src/board_mover.sv */
`default_nettype none
`timescale 1ns/1ns

module board_mover (
    input  wire board_pkg::grid_t grid,
    input  wire board_pkg::dir_e  dir,
    output board_pkg::grid_t      next_grid,
    output logic [15:0]           merges
);

    localparam int dim = board_pkg::grid_dim;

    board_pkg::line_t [dim-1:0]   lines_in;
    board_pkg::line_t [dim-1:0]   lines_out;
    logic [dim-1:0][dim-1:0]      line_merged;

    // cell of position i on line k, position 0 at the head of the slide
    function automatic int cell_of(input board_pkg::dir_e d, input int k, input int i);
        case (d)
            board_pkg::dir_left:  return k * dim + i;
            board_pkg::dir_right: return k * dim + (dim - 1 - i);
            board_pkg::dir_up:    return i * dim + k;
            default:              return (dim - 1 - i) * dim + k;
        endcase
    endfunction

    // gather rows or columns
    always_comb begin
        for (int k = 0; k < dim; k++) begin
            for (int i = 0; i < dim; i++) begin
                lines_in[k][i] = grid[cell_of(dir, k, i)];
            end
        end
    end

    for (genvar k = 0; k < dim; k++) begin : g_line
        line_slider u_line_slider (
            .line_in  (lines_in[k]),
            .line_out (lines_out[k]),
            .merged   (line_merged[k])
        );
    end

    // scatter back, each direction maps lines onto all cells once
    always_comb begin
        next_grid = '0;
        merges    = '0;
        for (int k = 0; k < dim; k++) begin
            for (int i = 0; i < dim; i++) begin
                next_grid[cell_of(dir, k, i)] = lines_out[k][i];
                merges[cell_of(dir, k, i)]    = line_merged[k][i];
            end
        end
    end

endmodule

`default_nettype wire

/* src/move_checker.sv */
`default_nettype none
`timescale 1ns/1ns

module move_checker (
    input  wire board_pkg::grid_t grid,
    output logic                  movable
);

    localparam int dim = board_pkg::grid_dim;

    logic any_empty;
    logic any_pair;

    always_comb begin
        any_empty = 1'b0;
        for (int c = 0; c < board_pkg::num_cells; c++) begin
            if (grid[c] == '0)
                any_empty = 1'b1;
        end
    end

    // an empty cell already sets movable, so zero pairs need no filter
    always_comb begin
        any_pair = 1'b0;
        for (int r = 0; r < dim; r++) begin
            for (int c = 0; c < dim - 1; c++) begin
                if (grid[r*dim + c] == grid[r*dim + c + 1])
                    any_pair = 1'b1;  // horizontal
            end
        end
        for (int r = 0; r < dim - 1; r++) begin
            for (int c = 0; c < dim; c++) begin
                if (grid[r*dim + c] == grid[(r+1)*dim + c])
                    any_pair = 1'b1;  // vertical
            end
        end
    end

    assign movable = any_empty | any_pair;

endmodule

`default_nettype wire

/* src/tile_array.sv */
`default_nettype none
`timescale 1ns/1ns

module tile_array (
    input  wire                       clk,
    input  wire                       rst,
    input  wire board_pkg::preset_t   preset,
    input  wire [3:0]                 move_req,
    input  wire board_pkg::grid_t     moved_grid,
    input  wire [15:0]                moved_merges,
    output board_pkg::grid_t          grid,
    output board_pkg::dir_e           move_dir,
    output logic [3:0]                done,
    output logic [15:0]               merges
);

    logic move_go;

    // a preset in the same cycle wins over the move
    assign move_go = (move_req != 4'b0000) && !preset.en;

    // one-hot strobe to direction code
    always_comb begin
        case (1'b1)
            move_req[1]: move_dir = board_pkg::dir_right;
            move_req[2]: move_dir = board_pkg::dir_up;
            move_req[3]: move_dir = board_pkg::dir_down;
            default:     move_dir = board_pkg::dir_left;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            grid   <= '0;
            done   <= 4'b0000;
            merges <= '0;
        end else begin
            done <= 4'b0000;  // pulse lasts one cycle
            if (preset.en) begin
                grid[preset.loc] <= preset.value;
                merges           <= '0;
            end else if (move_go) begin
                grid   <= moved_grid;
                merges <= moved_merges;
                done   <= move_req;
            end
        end
    end

    // only one direction may be requested at a time
    a_move_req_onehot : assert property (
        @(posedge clk) disable iff (!rst)
        $onehot0(move_req)
    ) else $error("move strobe requests more than one direction");

    // at most one done bit per pulse
    a_done_onehot : assert property (
        @(posedge clk) disable iff (!rst)
        $onehot0(done)
    ) else $error("done pulse names more than one direction");

endmodule

`default_nettype wire

/* src/board_top.sv */
`default_nettype none
`timescale 1ns/1ns

// 4x4 board, one-cycle preset and move
module board_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     preset_ext,
    input  wire [3:0]               preset_location,
    input  wire board_pkg::tile_t   value_from_preset,
    input  wire [3:0]               ready_from_global,
    output board_pkg::grid_t        total_current_state,
    output logic [3:0]              board_done,
    output logic                    movable,
    output logic [15:0]             score
);

    board_pkg::preset_t preset;
    board_pkg::grid_t   moved_grid;
    board_pkg::dir_e    move_dir;
    logic [15:0]        moved_merges;

    assign preset = '{
        en:    preset_ext,
        loc:   preset_location,
        value: value_from_preset
    };

    tile_array u_tile_array (
        .clk          (clk),
        .rst          (rst),
        .preset       (preset),
        .move_req     (ready_from_global),
        .moved_grid   (moved_grid),
        .moved_merges (moved_merges),
        .grid         (total_current_state),
        .move_dir     (move_dir),
        .done         (board_done),
        .merges       (score)
    );

    // next state for whichever direction is requested
    board_mover u_board_mover (
        .grid      (total_current_state),
        .dir       (move_dir),
        .next_grid (moved_grid),
        .merges    (moved_merges)
    );

    move_checker u_move_checker (
        .grid    (total_current_state),
        .movable (movable)
    );

endmodule

`default_nettype wire

/* include/tb_board_model.svh */
`ifndef TB_BOARD_MODEL_SVH
`define TB_BOARD_MODEL_SVH

// reference model for the board, holds one pending tile while scanning a line
function automatic board_pkg::line_t model_slide(input board_pkg::line_t l,
                                                 output logic [3:0] mrg);
    board_pkg::line_t res;
    board_pkg::tile_t pend;  // waits for a possible partner
    int               n;
    res  = '0;
    mrg  = '0;
    pend = '0;
    n    = 0;
    for (int i = 0; i < board_pkg::grid_dim; i++) begin
        if (l[i] != '0) begin
            if (pend == '0) begin
                pend = l[i];
            end else if (pend == l[i]) begin
                res[n] = (pend == board_pkg::tile_max) ? pend : pend + board_pkg::tile_t'(1);
                mrg[n] = 1'b1;
                n++;
                pend = '0;
            end else begin
                res[n] = pend;
                n++;
                pend = l[i];
            end
        end
    end
    if (pend != '0)
        res[n] = pend;
    return res;
endfunction

function automatic int model_cell(input board_pkg::dir_e d, input int k, input int i);
    case (d)
        board_pkg::dir_left:  return 4 * k + i;
        board_pkg::dir_right: return 4 * k + 3 - i;
        board_pkg::dir_up:    return 4 * i + k;
        default:              return 4 * (3 - i) + k;
    endcase
endfunction

function automatic board_pkg::grid_t model_move(input board_pkg::grid_t g,
                                                input board_pkg::dir_e d,
                                                output logic [15:0] mrg);
    board_pkg::grid_t res;
    board_pkg::line_t l;
    board_pkg::line_t s;
    logic [3:0]       lm;
    res = '0;
    mrg = '0;
    for (int k = 0; k < 4; k++) begin
        for (int i = 0; i < 4; i++)
            l[i] = g[model_cell(d, k, i)];
        s = model_slide(l, lm);
        for (int i = 0; i < 4; i++) begin
            res[model_cell(d, k, i)] = s[i];
            mrg[model_cell(d, k, i)] = lm[i];
        end
    end
    return res;
endfunction

// movable when some direction changes the grid
function automatic bit model_movable(input board_pkg::grid_t g);
    logic [15:0] unused_mrg;
    for (int d = 0; d < 4; d++) begin
        if (model_move(g, board_pkg::dir_e'(d), unused_mrg) != g)
            return 1'b1;
    end
    return 1'b0;
endfunction

`endif

/* dv/tb_board.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_board;

    `include "tb_board_model.svh"

    localparam int n_presets = 40;
    localparam int n_moves   = 30;
    localparam int n_prio    = 8;
    localparam int n_random  = 60;
    // a preset takes 2 cycles, a move 3, a board fill 16 presets
    localparam int test_cycles = 20 + n_presets * 2 + n_moves * 35 + 12 * 35
                                 + n_prio * 2 + 40 + n_random * 3;
    localparam int timeout_cycles = 2 * test_cycles + 100;

    logic                 clk;
    logic                 rst;
    logic                 preset_ext;
    logic [3:0]           preset_location;
    board_pkg::tile_t     value_from_preset;
    logic [3:0]           ready_from_global;
    board_pkg::grid_t     total_current_state;
    logic [3:0]           board_done;
    logic                 movable;
    logic [15:0]          score;

    board_pkg::grid_t     model_grid;
    logic [15:0]          exp_score;
    logic [31:0]          rng_state = 32'd69789;
    int                   n_pass = 0;
    int                   n_fail = 0;
    int                   fail_mark = 0;
    board_pkg::line_t     line_pat [3];
    board_pkg::line_t     left_result [3];

    board_top i_dut (
        .clk                 (clk),
        .rst                 (rst),
        .preset_ext          (preset_ext),
        .preset_location     (preset_location),
        .value_from_preset   (value_from_preset),
        .ready_from_global   (ready_from_global),
        .total_current_state (total_current_state),
        .board_done          (board_done),
        .movable             (movable),
        .score               (score)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // mostly small exponents so that merges happen, some empties and some saturated tiles
    function automatic board_pkg::tile_t random_tile();
        logic [31:0] r;
        r = next_random();
        if (r[1:0] == 2'd0)
            return '0;
        if (r[9:7] == 3'd0)
            return board_pkg::tile_max;
        return (r[5:2] % 4'd6) + 4'd1;
    endfunction

    function automatic board_pkg::dir_e random_dir();
        logic [31:0] r;
        r = next_random();
        return board_pkg::dir_e'(r[3:2]);
    endfunction

    // any empty cell counts, even on a blank board where no slide changes anything
    function automatic bit expected_movable(input board_pkg::grid_t g);
        for (int c = 0; c < 16; c++) begin
            if (g[c] == '0)
                return 1'b1;
        end
        return model_movable(g);
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            n_fail++;
            $display("Fail %s expected 0x%0h got 0x%0h at %0t", name, expected, actual, $time);
        end else begin
            n_pass++;
        end
    endtask

    task automatic check_state(input logic [3:0] exp_done);
        check_value("total_current_state", model_grid, total_current_state);
        check_value("board_done", 64'(exp_done), 64'(board_done));
        check_value("score", 64'(exp_score), 64'(score));
        check_value("movable", 64'(expected_movable(model_grid)), 64'(movable));
    endtask

    task automatic finish_test(input string name);
        $display("test %s finished with %0d errors", name, n_fail - fail_mark);
        fail_mark = n_fail;
    endtask

    // inputs are held for one edge, then the result is sampled at the falling edge
    task automatic apply_inputs(input logic pe, input logic [3:0] loc,
                                input board_pkg::tile_t val, input logic [3:0] mv);
        @(posedge clk);
        preset_ext        <= pe;
        preset_location   <= loc;
        value_from_preset <= val;
        ready_from_global <= mv;
        @(posedge clk);
        preset_ext        <= 1'b0;
        ready_from_global <= 4'b0000;
        @(negedge clk);
    endtask

    task automatic do_preset(input logic [3:0] loc, input board_pkg::tile_t val);
        apply_inputs(1'b1, loc, val, 4'b0000);
        model_grid[loc] = val;
        exp_score       = '0;
        check_state(4'b0000);
    endtask

    task automatic do_move(input board_pkg::dir_e d);
        logic [15:0] m;
        apply_inputs(1'b0, 4'd0, '0, 4'b0001 << d);
        model_grid = model_move(model_grid, d, m);
        exp_score  = m;
        check_state(4'b0001 << d);
        @(negedge clk);
        check_state(4'b0000);  // pulse gone, state held
    endtask

    task automatic fill_random_board();
        for (int c = 0; c < 16; c++)
            do_preset(4'(c), random_tile());
    endtask

    initial begin
        rst               = 1'b0;
        preset_ext        = 1'b0;
        preset_location   = 4'd0;
        value_from_preset = '0;
        ready_from_global = 4'b0000;
        model_grid        = '0;
        exp_score         = '0;
        line_pat[0]    = {4'd1, 4'd1, 4'd1, 4'd1};
        line_pat[1]    = {4'd2, 4'd2, 4'd0, 4'd2};
        line_pat[2]    = {4'd0, 4'd0, 4'd15, 4'd15};
        left_result[0] = {4'd0, 4'd0, 4'd2, 4'd2};
        left_result[1] = {4'd0, 4'd0, 4'd2, 4'd3};
        left_result[2] = {4'd0, 4'd0, 4'd0, 4'd15};

        repeat (10) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_state(4'b0000);
        check_value("movable", 64'd1, 64'(movable));
        finish_test("reset_state");

        for (int t = 0; t < n_presets; t++)
            do_preset(4'(next_random() >> 28), random_tile());
        finish_test("preset_write");

        for (int t = 0; t < n_moves; t++) begin
            fill_random_board();
            do_move(random_dir());
        end
        finish_test("random_moves");

        for (int p = 0; p < 3; p++) begin
            for (int d = 0; d < 4; d++) begin
                for (int c = 0; c < 16; c++)
                    do_preset(4'(c), line_pat[p][c % 4]);  // same line in every row
                do_move(board_pkg::dir_e'(d));
                if (d == 0)
                    check_value("row 0", 64'(left_result[p]), 64'(total_current_state[3:0]));
            end
        end
        finish_test("merge_edges");

        for (int t = 0; t < n_prio; t++) begin
            logic [3:0]       loc;
            board_pkg::tile_t val;
            loc = 4'(next_random() >> 28);
            val = random_tile();
            apply_inputs(1'b1, loc, val, 4'b0001 << random_dir());
            model_grid[loc] = val;
            exp_score       = '0;
            check_state(4'b0000);
        end
        finish_test("preset_priority");

        for (int c = 0; c < 16; c++)
            do_preset(4'(c), (((c / 4) + (c % 4)) % 2 == 1) ? 4'd1 : 4'd2);
        check_value("movable", 64'd0, 64'(movable));
        do_preset(4'd0, 4'd1);  // now equals its right neighbour
        check_value("movable", 64'd1, 64'(movable));
        do_preset(4'd0, 4'd2);
        check_value("movable", 64'd0, 64'(movable));
        do_preset(4'd5, 4'd0);
        check_value("movable", 64'd1, 64'(movable));
        for (int t = 0; t < n_random; t++) begin
            if (next_random() % 3 == 0)
                do_preset(4'(next_random() >> 28), random_tile());
            else
                do_move(random_dir());
        end
        finish_test("movable_flag");

        $display("checks passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("the run timed out after %0d cycles", timeout_cycles);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
src/board_pkg.sv
src/line_slider.sv
src/board_mover.sv
src/move_checker.sv
src/tile_array.sv
src/board_top.sv
dv/tb_board.sv

/* Makefile */
SOURCES := verilog.f $(wildcard src/*.sv dv/*.sv include/*.svh)

.PHONY: all run clean

all: obj_dir/Vtb_board

obj_dir/Vtb_board: $(SOURCES)
	verilator --binary --timing --assert -f verilog.f --top-module tb_board \
		-Mdir obj_dir -o Vtb_board

run: obj_dir/Vtb_board
	./obj_dir/Vtb_board | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
